//--- verif/div_patterns.txt
# numerator denominator class dbz (operands in hex)
# class N normal, Z zero, I infinity, X NaN; dbz is the expected div_by_zero flag
3F80 3F80 N 0
4000 3F80 N 0
3F80 4040 N 0
40E0 4040 N 0
C020 4000 N 0
4120 BF80 N 0
C0A0 C0E0 N 0
42C8 3DCD N 0
4049 3FF3 N 0
3FFF 3F81 N 0
5015 42F6 N 0
BF00 4110 N 0
7FC0 3F80 X 0
3F80 7FC1 X 0
0000 0000 X 0
7F80 FF80 X 0
FF81 0000 X 0
3F80 0000 I 1
C040 0000 I 1
3F80 8000 I 1
7F80 0000 I 1
4000 0005 I 1
7F80 3F80 I 0
FF80 4000 I 0
0000 3F80 Z 0
8000 4040 Z 0
3F80 7F80 Z 0
0003 3F80 Z 0
7F00 3E80 I 0
7F7F 3C00 I 0
0080 4200 Z 0
8100 5000 Z 0

//--- compile.f
common/gs_div_pkg.sv
common/gs_stage_if.sv
source/gs_pipe_slice.sv
goldschmidt/gs_prescale.sv
goldschmidt/gs_iteration.sv
goldschmidt/gs_result.sv
source/bf16_goldschmidt_div.sv
verif/tb_clk_gen.sv
verif/tb_bf16_div.sv

//--- Bender.yml
package:
  name: bf16_goldschmidt_div

sources:
  - common/gs_div_pkg.sv
  - common/gs_stage_if.sv
  - source/gs_pipe_slice.sv
  - goldschmidt/gs_prescale.sv
  - goldschmidt/gs_iteration.sv
  - goldschmidt/gs_result.sv
  - source/bf16_goldschmidt_div.sv
  - target: any(simulation, test)
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_bf16_div.sv

//--- verif/tb_bf16_div.sv
module tb_bf16_div
        import gs_div_pkg::*;
();

        timeunit 1ns;
        timeprecision 1ps;

        localparam int    ITERATIONS   = 2;
        localparam int    LUT_DEPTH    = 32;
        localparam int    TIMEOUT      = 1000;
        localparam string PATTERN_FILE = "verif/div_patterns.txt";

        typedef struct {
                bf16_t a;
                bf16_t b;
                byte   cls;
                bit    dbz;
        } pattern_t;

        logic     clk;
        logic     rst_n;
        logic     in_valid;
        logic     in_ready;
        logic     out_ready;
        logic     out_valid;
        logic     div_by_zero;
        logic     is_inf;
        logic     is_nan;
        bf16_t    numerator;
        bf16_t    denominator;
        bf16_t    quotient;
        pattern_t patterns[$];
        pattern_t pending[$];
        int       seed;
        bit       random_ready;

        tb_clk_gen #(
                .CLK_PERIOD   (10),
                .RESET_CYCLES (2)
        ) tb_clk_gen_i (
                .o_clk   (clk),
                .o_rst_n (rst_n)
        );

        bf16_goldschmidt_div #(
                .ITERATIONS (ITERATIONS),
                .LUT_DEPTH  (LUT_DEPTH)
        ) bf16_goldschmidt_div_i (
                .i_clk         (clk),
                .i_rst_n       (rst_n),
                .i_in_valid    (in_valid),
                .i_numerator   (numerator),
                .i_denominator (denominator),
                .o_in_ready    (in_ready),
                .i_out_ready   (out_ready),
                .o_out_valid   (out_valid),
                .o_quotient    (quotient),
                .o_div_by_zero (div_by_zero),
                .o_is_inf      (is_inf),
                .o_is_nan      (is_nan)
        );

        // ====================
        // Helpers
        // ====================

        task automatic abort_run(input string line);
                $display("%s", line);
                $display("SOME TESTS FAILED");
                $fatal(1, "Run stopped at the first error");
        endtask

        function automatic real pow2(input int e);
                real r;
                r = 1.0;
                for (int i = 0; i < e; i++)
                        r = r * 2.0;
                for (int i = 0; i < -e; i++)
                        r = r / 2.0;
                return r;
        endfunction

        // Denormal operands read as zero
        function automatic real bf16_to_real(input bf16_t v);
                real mag;
                if (v[14:7] == 8'd0)
                        mag = 0.0;
                else
                        mag = (1.0 + v[6:0] / 128.0) * pow2(int'(v[14:7]) - 127);
                return v[15] ? -mag : mag;
        endfunction

        // Weight of the last mantissa bit at the exponent of x
        function automatic real ulp_of(input real x);
                real m;
                int  k;
                m = (x < 0.0) ? -x : x;
                k = 0;
                while (m >= 2.0) begin
                        m = m / 2.0;
                        k++;
                end
                while (m < 1.0) begin
                        m = m * 2.0;
                        k--;
                end
                return pow2(k - 7);
        endfunction

        task automatic load_patterns();
                int          fd;
                int          code;
                string       line;
                logic [15:0] a_val;
                logic [15:0] b_val;
                byte         cls_val;
                int          dbz_val;
                pattern_t    p;
                fd = $fopen(PATTERN_FILE, "r");
                if (fd == 0)
                        abort_run("Could not open the pattern file verif/div_patterns.txt");
                while (!$feof(fd)) begin
                        code = $fgets(line, fd);
                        if (code != 0 && line.len() > 1 && line.getc(0) != "#") begin
                                code = $sscanf(line, "%h %h %c %d", a_val, b_val, cls_val, dbz_val);
                                if (code != 4 || !(cls_val inside {"N", "Z", "I", "X"}))
                                        abort_run($sformatf("Malformed pattern line: %s", line));
                                p.a   = a_val;
                                p.b   = b_val;
                                p.cls = cls_val;
                                p.dbz = dbz_val[0];
                                patterns.push_back(p);
                        end
                end
                $fclose(fd);
                if (patterns.size() == 0)
                        abort_run("The pattern file holds no patterns");
        endtask

        // ====================
        // Stimulus
        // ====================

        // Starts just after a rising edge and returns just after the transfer edge
        task automatic send_item(input pattern_t p);
                int waited;
                in_valid    = 1'b1;
                numerator   = p.a;
                denominator = p.b;
                waited      = 0;
                @(negedge clk);
                while (!in_ready) begin
                        waited++;
                        if (waited > TIMEOUT)
                                abort_run("Timeout: the DUT never accepted an input");
                        @(negedge clk);
                end
                pending.push_back(p);
                @(posedge clk);
                #1;
                in_valid = 1'b0;
        endtask

        task automatic drain();
                int waited;
                waited = 0;
                while (pending.size() != 0) begin
                        @(negedge clk);
                        waited++;
                        if (waited > TIMEOUT)
                                abort_run("Timeout: results still outstanding after the last input");
                end
                @(posedge clk);
                #1;
        endtask

        always @(posedge clk) begin
                #1;
                if (random_ready)
                        out_ready = ($random(seed) & 1) != 0;
                else
                        out_ready = 1'b1;
        end

        // ====================
        // Checker
        // ====================

        task automatic check_output(input pattern_t p);
                bit    sign;
                real   exact;
                real   got;
                real   err;
                string tag;
                sign = p.a[15] ^ p.b[15];
                tag  = $sformatf("FAIL at %0t ns: %h / %h gave %h", $time, p.a, p.b, quotient);
                assert (quotient[15] == sign)
                else abort_run($sformatf("%s, sign should be %b", tag, sign));
                assert (div_by_zero == p.dbz)
                else abort_run($sformatf("%s, div_by_zero should be %b", tag, p.dbz));
                case (p.cls)
                        "N": begin
                                assert (!is_nan && !is_inf && quotient[14:7] != 8'h00
                                        && quotient[14:7] != 8'hFF)
                                else abort_run($sformatf("%s, expected a finite normal", tag));
                                exact = bf16_to_real(p.a) / bf16_to_real(p.b);
                                got   = bf16_to_real(quotient);
                                err   = (got > exact) ? got - exact : exact - got;
                                assert (err <= 2.0 * ulp_of(got))
                                else abort_run($sformatf("%s = %g, exact %g", tag, got, exact));
                        end
                        "Z": assert (quotient[14:0] == 15'h0000 && !is_nan && !is_inf)
                                else abort_run($sformatf("%s, expected a signed zero", tag));
                        "I": assert (quotient[14:0] == 15'h7F80 && is_inf && !is_nan)
                                else abort_run($sformatf("%s, expected a signed infinity", tag));
                        default: assert (quotient[14:0] == 15'h7FC0 && is_nan && !is_inf)
                                else abort_run($sformatf("%s, expected the quiet NaN", tag));
                endcase
        endtask

        always @(negedge clk) begin
                if (rst_n && out_valid && out_ready) begin
                        assert (pending.size() != 0)
                        else abort_run($sformatf("FAIL at %0t ns: result %h with no input outstanding",
                                                 $time, quotient));
                        check_output(pending.pop_front());
                end
        end

        // ====================
        // Test sequence
        // ====================

        initial begin
                int waited;
                int cycles;
                in_valid     = 1'b0;
                numerator    = '0;
                denominator  = '0;
                out_ready    = 1'b1;
                random_ready = 1'b0;
                seed         = 56036;

                // Idle outputs while reset is held and just after it
                waited = 0;
                @(negedge clk);
                while (rst_n !== 1'b1) begin
                        assert (!out_valid && in_ready)
                        else abort_run($sformatf("FAIL at %0t ns: handshake not idle in reset", $time));
                        waited++;
                        if (waited > TIMEOUT)
                                abort_run("Timeout: reset was never released");
                        @(negedge clk);
                end
                assert (!out_valid && in_ready)
                else abort_run($sformatf("FAIL at %0t ns: handshake not idle after reset", $time));

                load_patterns();
                @(posedge clk);
                #1;

                // One isolated item with the output ready held high
                send_item(patterns[0]);
                cycles = 0;
                do begin
                        @(negedge clk);
                        cycles++;
                        if (cycles > TIMEOUT)
                                abort_run("Timeout: no result for the isolated latency item");
                end while (!out_valid);
                assert (cycles == ITERATIONS + 2)
                else abort_run($sformatf("FAIL at %0t ns: latency %0d cycles, expected %0d",
                                         $time, cycles, ITERATIONS + 2));
                drain();

                foreach (patterns[i])
                        send_item(patterns[i]);
                drain();

                // Same stream again with random back-pressure on the output
                random_ready = 1'b1;
                foreach (patterns[i])
                        send_item(patterns[i]);
                random_ready = 1'b0;
                drain();

                // A stray or duplicated item would surface within one pipeline latency
                repeat (ITERATIONS + 2) @(posedge clk);
                #1;

                if (!out_valid && in_ready) begin
                        $display("ALL TESTS PASSED");
                        $finish;
                end else begin
                        abort_run($sformatf("FAIL at %0t ns: pipeline still busy after the last result",
                                            $time));
                end
        end

endmodule

//--- verif/tb_clk_gen.sv
module tb_clk_gen #(
        parameter int CLK_PERIOD   = 10,
        parameter int RESET_CYCLES = 2
) (
        output logic o_clk,
        output logic o_rst_n
);

        timeunit 1ns;
        timeprecision 1ps;

        initial begin
                o_clk = 1'b0;
                forever #(CLK_PERIOD / 2) o_clk = ~o_clk;
        end

        // Release lands just after a rising edge, like the rest of the stimulus
        initial begin
                o_rst_n = 1'b0;
                repeat (RESET_CYCLES) @(posedge o_clk);
                #1;
                o_rst_n = 1'b1;
        end

endmodule

//--- source/bf16_goldschmidt_div.sv
module bf16_goldschmidt_div
        import gs_div_pkg::*;
#(
        parameter int ITERATIONS = 2,
        parameter int LUT_DEPTH  = 32
) (
        input  logic  i_clk,
        input  logic  i_rst_n,
        input  logic  i_in_valid,
        input  bf16_t i_numerator,
        input  bf16_t i_denominator,
        output logic  o_in_ready,
        input  logic  i_out_ready,
        output logic  o_out_valid,
        output bf16_t o_quotient,
        output logic  o_div_by_zero,
        output logic  o_is_inf,
        output logic  o_is_nan
);

        // Link k feeds iteration k, the last link feeds the result stage
        gs_stage_if stage_if [0:ITERATIONS] ();

        // ====================
        // Front end
        // ====================

        gs_prescale #(
                .LUT_DEPTH (LUT_DEPTH)
        ) gs_prescale_i (
                .i_clk         (i_clk),
                .i_rst_n       (i_rst_n),
                .i_valid       (i_in_valid),
                .i_numerator   (i_numerator),
                .i_denominator (i_denominator),
                .o_ready       (o_in_ready),
                .out           (stage_if[0])
        );

        // ====================
        // Iteration chain
        // ====================

        for (genvar k = 0; k < ITERATIONS; k++) begin : gen_iter
                gs_iteration gs_iteration_i (
                        .i_clk   (i_clk),
                        .i_rst_n (i_rst_n),
                        .in      (stage_if[k]),
                        .out     (stage_if[k+1])
                );
        end

        // ====================
        // Result stage
        // ====================

        gs_result gs_result_i (
                .i_clk         (i_clk),
                .i_rst_n       (i_rst_n),
                .i_out_ready   (i_out_ready),
                .in            (stage_if[ITERATIONS]),
                .o_out_valid   (o_out_valid),
                .o_quotient    (o_quotient),
                .o_div_by_zero (o_div_by_zero),
                .o_is_inf      (o_is_inf),
                .o_is_nan      (o_is_nan)
        );

endmodule

//--- goldschmidt/gs_result.sv
module gs_result
        import gs_div_pkg::*;
(
        input  logic     i_clk,
        input  logic     i_rst_n,
        input  logic     i_out_ready,
        gs_stage_if.sink in,
        output logic     o_out_valid,
        output bf16_t    o_quotient,
        output logic     o_div_by_zero,
        output logic     o_is_inf,
        output logic     o_is_nan
);

        logic              w_shift;
        fix_t              w_norm;
        logic signed [9:0] w_exp;
        gs_out_t           w_res;
        gs_out_t           w_q;

        // N lies in [0.5, 2), so only the ones bit decides the shift
        assign w_shift = !in.num[FRAC_W];
        assign w_norm  = w_shift ? {in.num[FRAC_W:0], 1'b0} : in.num;
        assign w_exp   = in.meta.exp_est - (w_shift ? 10'sd1 : 10'sd0);

        // ====================
        // Special-case priority
        // ====================

        always_comb begin
                w_res.is_nan      = 1'b0;
                w_res.is_inf      = 1'b0;
                w_res.div_by_zero = 1'b0;
                if (in.meta.special.force_nan) begin
                        w_res.quotient = {in.meta.sign, BF16_QNAN[BF16_W-2:0]};
                        w_res.is_nan   = 1'b1;
                end else if (in.meta.special.div_by_zero) begin
                        w_res.quotient    = {in.meta.sign, BF16_POS_INF[BF16_W-2:0]};
                        w_res.is_inf      = 1'b1;
                        w_res.div_by_zero = 1'b1;
                end else if (in.meta.special.force_inf) begin
                        w_res.quotient = {in.meta.sign, BF16_POS_INF[BF16_W-2:0]};
                        w_res.is_inf   = 1'b1;
                end else if (in.meta.special.force_zero) begin
                        w_res.quotient = {in.meta.sign, {(BF16_W-1){1'b0}}};
                end else if (w_exp > 10'sd254) begin
                        // Overflow past the largest finite exponent
                        w_res.quotient = {in.meta.sign, BF16_POS_INF[BF16_W-2:0]};
                        w_res.is_inf   = 1'b1;
                end else if (w_exp < 10'sd1) begin
                        w_res.quotient = {in.meta.sign, {(BF16_W-1){1'b0}}};
                end else begin
                        // Fraction truncated to the BF16 mantissa
                        w_res.quotient = {in.meta.sign, w_exp[EXP_W-1:0],
                                          w_norm[FRAC_W-1 -: MANT_W]};
                end
        end

        gs_pipe_slice #(
                .payload_t (gs_out_t)
        ) gs_pipe_slice_i (
                .i_clk   (i_clk),
                .i_rst_n (i_rst_n),
                .i_valid (in.valid),
                .i_data  (w_res),
                .i_ready (i_out_ready),
                .o_ready (in.ready),
                .o_valid (o_out_valid),
                .o_data  (w_q)
        );

        assign o_quotient    = w_q.quotient;
        assign o_is_nan      = w_q.is_nan;
        assign o_is_inf      = w_q.is_inf;
        assign o_div_by_zero = w_q.div_by_zero;

endmodule

//--- goldschmidt/gs_iteration.sv
module gs_iteration
        import gs_div_pkg::*;
(
        input  logic       i_clk,
        input  logic       i_rst_n,
        gs_stage_if.sink   in,
        gs_stage_if.source out
);

        localparam fix_t FIX_TWO = {2'b10, {FRAC_W{1'b0}}};

        fix_t      w_f;
        gs_state_t w_next;
        gs_state_t w_q;

        // ====================
        // Goldschmidt step
        // ====================

        // D stays near 1, so 2 - D never wraps
        assign w_f = FIX_TWO - in.den;

        // Both products are independent and are formed side by side
        always_comb begin
                w_next.num  = fix_mul(in.num, w_f);
                w_next.den  = fix_mul(in.den, w_f);
                w_next.meta = in.meta;
        end

        // ====================
        // Stage register
        // ====================

        gs_pipe_slice #(
                .payload_t (gs_state_t)
        ) gs_pipe_slice_i (
                .i_clk   (i_clk),
                .i_rst_n (i_rst_n),
                .i_valid (in.valid),
                .i_data  (w_next),
                .i_ready (out.ready),
                .o_ready (in.ready),
                .o_valid (out.valid),
                .o_data  (w_q)
        );

        assign out.num  = w_q.num;
        assign out.den  = w_q.den;
        assign out.meta = w_q.meta;

endmodule

//--- goldschmidt/gs_prescale.sv
module gs_prescale
        import gs_div_pkg::*;
#(
        parameter int LUT_DEPTH = 32
) (
        input  logic       i_clk,
        input  logic       i_rst_n,
        input  logic       i_valid,
        input  bf16_t      i_numerator,
        input  bf16_t      i_denominator,
        output logic       o_ready,
        gs_stage_if.source out
);

        localparam int IDX_W = $clog2(LUT_DEPTH);

        typedef logic [LUT_DEPTH-1:0][FRAC_W+1:0] lut_t;

        // ====================
        // Reciprocal LUT
        // ====================

        // 1/(1.m) taken at the midpoint of each interval, rounded to nearest
        function automatic lut_t build_lut();
                lut_t lut;
                int   den;
                for (int i = 0; i < LUT_DEPTH; i++) begin
                        den    = 2 * LUT_DEPTH + 2 * i + 1;
                        lut[i] = fix_t'(((2 * LUT_DEPTH) * (1 << FRAC_W) + den / 2) / den);
                end
                return lut;
        endfunction

        localparam lut_t RECIP_LUT = build_lut();

        // Denormals fall into the zero class
        function automatic operand_class_t classify(bf16_t v);
                logic [EXP_W-1:0]  e;
                logic [MANT_W-1:0] m;
                e = v[BF16_W-2 -: EXP_W];
                m = v[MANT_W-1:0];
                if (e == '0)
                        return CLS_ZERO;
                else if (e == '1)
                        return (m == '0) ? CLS_INF : CLS_NAN;
                else
                        return CLS_NORMAL;
        endfunction

        logic [EXP_W-1:0]  w_a_exp;
        logic [EXP_W-1:0]  w_b_exp;
        logic [MANT_W-1:0] w_a_mant;
        logic [MANT_W-1:0] w_b_mant;
        operand_class_t    w_a_cls;
        operand_class_t    w_b_cls;
        fix_t              w_recip;
        fix_t              w_a_fix;
        fix_t              w_b_fix;
        gs_state_t         w_next;
        gs_state_t         w_q;

        assign w_a_exp  = i_numerator[BF16_W-2 -: EXP_W];
        assign w_b_exp  = i_denominator[BF16_W-2 -: EXP_W];
        assign w_a_mant = i_numerator[MANT_W-1:0];
        assign w_b_mant = i_denominator[MANT_W-1:0];
        assign w_a_cls  = classify(i_numerator);
        assign w_b_cls  = classify(i_denominator);

        // Mantissas with the hidden one, placed in the fixed-point frame
        assign w_a_fix = {2'b01, w_a_mant, {(FRAC_W-MANT_W){1'b0}}};
        assign w_b_fix = {2'b01, w_b_mant, {(FRAC_W-MANT_W){1'b0}}};

        assign w_recip = RECIP_LUT[w_b_mant[MANT_W-1 -: IDX_W]];

        always_comb begin
                // Scale both so that D0 sits close to 1.0
                w_next.num = fix_mul(w_a_fix, w_recip);
                w_next.den = fix_mul(w_b_fix, w_recip);

                w_next.meta.sign    = i_numerator[BF16_W-1] ^ i_denominator[BF16_W-1];
                w_next.meta.exp_est = $signed({2'b00, w_a_exp}) - $signed({2'b00, w_b_exp})
                                      + 10'(EXP_BIAS);

                w_next.meta.special.force_nan   = (w_a_cls == CLS_NAN) || (w_b_cls == CLS_NAN)
                        || (w_a_cls == CLS_ZERO && w_b_cls == CLS_ZERO)
                        || (w_a_cls == CLS_INF && w_b_cls == CLS_INF);
                w_next.meta.special.div_by_zero = (w_b_cls == CLS_ZERO);
                w_next.meta.special.force_inf   = (w_a_cls == CLS_INF);
                w_next.meta.special.force_zero  = (w_a_cls == CLS_ZERO) || (w_b_cls == CLS_INF);
        end

        gs_pipe_slice #(
                .payload_t (gs_state_t)
        ) gs_pipe_slice_i (
                .i_clk   (i_clk),
                .i_rst_n (i_rst_n),
                .i_valid (i_valid),
                .i_data  (w_next),
                .i_ready (out.ready),
                .o_ready (o_ready),
                .o_valid (out.valid),
                .o_data  (w_q)
        );

        assign out.num  = w_q.num;
        assign out.den  = w_q.den;
        assign out.meta = w_q.meta;

endmodule

//--- source/gs_pipe_slice.sv
module gs_pipe_slice #(
        parameter type payload_t = logic [7:0]
) (
        input  logic     i_clk,
        input  logic     i_rst_n,
        input  logic     i_valid,
        input  payload_t i_data,
        input  logic     i_ready,
        output logic     o_ready,
        output logic     o_valid,
        output payload_t o_data
);

        logic     r_valid;
        payload_t r_data;

        // Accept when empty or when the held item leaves this cycle
        assign o_ready = !r_valid || i_ready;

        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        r_valid <= 1'b0;
                end else if (o_ready) begin
                        r_valid <= i_valid;
                end
        end

        always_ff @(posedge i_clk) begin
                if (i_valid && o_ready) begin
                        r_data <= i_data;
                end
        end

        assign o_valid = r_valid;
        assign o_data  = r_data;

endmodule

//--- common/gs_stage_if.sv
interface gs_stage_if
        import gs_div_pkg::*;
();

        logic     valid;
        logic     ready;
        fix_t     num;
        fix_t     den;
        gs_meta_t meta;

        // Item moves when valid and ready are both high on a rising edge
        modport source (
                output valid,
                output num,
                output den,
                output meta,
                input  ready
        );

        modport sink (
                input  valid,
                input  num,
                input  den,
                input  meta,
                output ready
        );

endinterface

//--- common/gs_div_pkg.sv
package gs_div_pkg;

        // ====================
        // BF16 format
        // ====================

        localparam int BF16_W   = 16;
        localparam int EXP_W    = 8;
        localparam int MANT_W   = 7;
        localparam int EXP_BIAS = 127;

        // Mantissa datapath is unsigned, 2 integer bits and FRAC_W fraction bits
        localparam int FRAC_W = 14;

        localparam logic [BF16_W-1:0] BF16_QNAN    = 16'h7FC0;
        localparam logic [BF16_W-1:0] BF16_POS_INF = 16'h7F80;

        typedef logic [BF16_W-1:0] bf16_t;
        typedef logic [FRAC_W+1:0] fix_t;

        // ====================
        // Operand and stage types
        // ====================

        typedef enum logic [1:0] {
                CLS_NORMAL = 2'd0,
                CLS_ZERO   = 2'd1,
                CLS_INF    = 2'd2,
                CLS_NAN    = 2'd3
        } operand_class_t;

        // Raw special-case conditions, priority is resolved in the result stage
        typedef struct packed {
                logic force_nan;
                logic force_inf;
                logic force_zero;
                logic div_by_zero;
        } special_t;

        typedef struct packed {
                logic              sign;
                logic signed [9:0] exp_est;
                special_t          special;
        } gs_meta_t;

        typedef struct packed {
                fix_t     num;
                fix_t     den;
                gs_meta_t meta;
        } gs_state_t;

        typedef struct packed {
                bf16_t quotient;
                logic  is_nan;
                logic  is_inf;
                logic  div_by_zero;
        } gs_out_t;

        // Fixed-point product, fraction truncated and top integer bits dropped
        function automatic fix_t fix_mul(fix_t a, fix_t b);
                logic [2*FRAC_W+3:0] prod;
                prod = a * b;
                return prod[FRAC_W +: FRAC_W+2];
        endfunction

endpackage
